//--- encoderTop.f
common/encoderPkg.sv
prefix/PrefixXor.sv
prefix/Gray2Bin.sv
logic/encoderSampler.sv
logic/sampleHistory.sv
logic/positionTracker.sv
logic/encoderTop.sv
verif/encoderTopTb.sv

//--- verif/encoderTopTb.sv
`timescale 1ns/1ps

module encoderTopTb;

	import encoderPkg::*;

	// expected outputs for one tick, in tick order
	typedef struct packed {
		pos_t   pos;
		turn_t  turns;
		delta_t vel;
		logic   velValid;
		logic   jumpErr;
	} expect_t;

	localparam int drainLimit = 20;  // cycles allowed for the pipeline to empty

	logic   clk;
	logic   rstN;
	gray_t  grayIn;
	logic   sampleTick;
	pos_t   position;
	turn_t  turns;
	delta_t velocity;
	logic   velValid;
	logic   trackValid;
	logic   jumpErr;

	logic [31:0] rngState = 32'd85;
	logic [1:0]  tickPipe;      // tick delayed by one and two edges
	logic        failed = 1'b0;
	logic        jumpSeen = 1'b0;  // model of the sticky flag
	int          shaft = 0;        // multi-turn shaft angle, model side
	int          shaftLog [$];     // earlier sampled angles, newest first
	expect_t     expQ [$];
	int          tickCount = 0;
	int          doneCount = 0;
	int          step;

	encoderTop UUT (
		.clk       (clk),
		.rstN      (rstN),
		.grayIn    (grayIn),
		.sampleTick(sampleTick),
		.position  (position),
		.turns     (turns),
		.velocity  (velocity),
		.velValid  (velValid),
		.trackValid(trackValid),
		.jumpErr   (jumpErr)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic gray_t toGray(input pos_t b);
		return b ^ (b >> 1);  // sensor encoding
	endfunction

	task automatic reportMismatch(input string name, input logic [31:0] got,
			input logic [31:0] want);
		$display("ERROR %s: got 0x%h, expected 0x%h", name, got, want);
		failed = 1'b1;
	endtask

	task automatic reportFailure(input string what);
		$display("%s", what);
		failed = 1'b1;
	endtask

	// model update for one tick, then raise the strobe
	task automatic issueTick();
		expect_t e;
		int diff;
		e.pos = pos_t'(shaft);
		e.turns = turn_t'(shaft >>> posWidth);  // floor of angle over one turn
		e.velValid = (shaftLog.size() >= histDepth);
		e.vel = e.velValid ? delta_t'(shaft - shaftLog[histDepth-1]) : '0;
		if (shaftLog.size() > 0) begin
			diff = shaft - shaftLog[0];
			if ((diff < 0 ? -diff : diff) > maxStep) begin
				jumpSeen = 1'b1;
			end
		end
		e.jumpErr = jumpSeen;
		shaftLog.push_front(shaft);
		if (shaftLog.size() > histDepth) begin
			void'(shaftLog.pop_back());
		end
		expQ.push_back(e);
		tickCount++;
		sampleTick = 1'b1;
	endtask

	task automatic waitDrained();
		int cycles;
		cycles = 0;
		while (doneCount != tickCount && cycles < drainLimit) begin
			@(posedge clk);
			cycles++;
		end
		if (doneCount != tickCount) begin
			reportFailure("timed out waiting for trackValid after a tick");
		end
	endtask

	// move the shaft, hold 3 cycles, then one tick
	task automatic stepAngle(input int delta);
		shaft += delta;
		@(posedge clk);
		#1 grayIn = toGray(pos_t'(shaft));
		repeat (3) @(posedge clk);
		#1 issueTick();
		@(posedge clk);
		#1 sampleTick = 1'b0;
		waitDrained();
	endtask

	always @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			tickPipe <= '0;
		end else begin
			tickPipe <= {tickPipe[0], sampleTick};
		end
	end

	// outputs are stable at the falling edge
	always @(negedge clk) begin : checkOutputs
		expect_t want;
		if (rstN) begin
			assert (trackValid === tickPipe[1])
				else reportMismatch("trackValid", 32'(trackValid), 32'(tickPipe[1]));
			if (trackValid) begin
				if (expQ.size() == 0) begin
					reportFailure("trackValid pulsed with no tick outstanding");
				end else begin
					want = expQ.pop_front();
					assert (position === want.pos)
						else reportMismatch("position", 32'(position), 32'(want.pos));
					assert (turns === want.turns)
						else reportMismatch("turns", 32'(turns), 32'(want.turns));
					assert (velValid === want.velValid)
						else reportMismatch("velValid", 32'(velValid), 32'(want.velValid));
					assert (jumpErr === want.jumpErr)
						else reportMismatch("jumpErr", 32'(jumpErr), 32'(want.jumpErr));
					if (want.velValid) begin
						assert (velocity === want.vel)
							else reportMismatch("velocity", 32'(velocity), 32'(want.vel));
					end
					doneCount++;
				end
			end
		end
	end

	initial begin : failWatch
		wait (failed);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	end

	initial begin
		rstN = 1'b0;
		grayIn = '0;
		sampleTick = 1'b0;
		repeat (4) @(posedge clk);
		#1 rstN = 1'b1;
		@(negedge clk);
		assert (trackValid === 1'b0) else reportMismatch("trackValid", 32'(trackValid), 0);
		assert (velValid === 1'b0) else reportMismatch("velValid", 32'(velValid), 0);
		assert (jumpErr === 1'b0) else reportMismatch("jumpErr", 32'(jumpErr), 0);
		assert (position === '0) else reportMismatch("position", 32'(position), 0);
		assert (turns === '0) else reportMismatch("turns", 32'(turns), 0);

		stepAngle(100);  // first sample, no prior angle

		// random small walk, both directions
		for (int i = 0; i < 30; i++) begin
			rngState = xorshift32(rngState);
			step = int'(rngState % 97);
			rngState = xorshift32(rngState);
			if (rngState[0]) begin
				step = -step;
			end
			stepAngle(step);
		end

		// forward through 4095 -> 0
		while (shaft < 4196) begin
			stepAngle(150);
		end
		assert (turns === turn_t'(1)) else reportMismatch("turns", 32'(turns), 1);

		// backward through 0 -> 4095
		while (shaft > -100) begin
			stepAngle(-150);
		end
		assert (turns === turn_t'(-1)) else reportMismatch("turns", 32'(turns), 32'hff);
		assert (jumpErr === 1'b0) else reportMismatch("jumpErr", 32'(jumpErr), 0);

		stepAngle(1000);  // beyond maxStep
		for (int i = 0; i < 5; i++) begin
			stepAngle(20);
		end
		assert (jumpErr === 1'b1) else reportMismatch("jumpErr", 32'(jumpErr), 1);

		// angle held, tick every cycle
		repeat (3) @(posedge clk);
		for (int i = 0; i < 8; i++) begin
			@(posedge clk);
			#1 issueTick();
		end
		@(posedge clk);
		#1 sampleTick = 1'b0;
		waitDrained();

		repeat (2) @(posedge clk);
		if (!failed) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			$display("FAIL: see errors above");
			$fatal(1, "stopped with errors");
		end
	end

endmodule

//--- logic/encoderTop.sv
`timescale 1ns/1ps

module encoderTop (
	input  logic               clk,
	input  logic               rstN,
	input  encoderPkg::gray_t  grayIn,      // async from sensor
	input  logic               sampleTick,
	output encoderPkg::pos_t   position,
	output encoderPkg::turn_t  turns,
	output encoderPkg::delta_t velocity,
	output logic               velValid,
	output logic               trackValid,  // tick + 2 cycles
	output logic               jumpErr
);

	import encoderPkg::*;

	posSample_t sample;     // strobe from sampler
	pos_t       prevPos;
	pos_t       windowPos;
	logic       full;       // history window filled

	encoderSampler sampler (
		.clk       (clk),
		.rstN      (rstN),
		.grayIn    (grayIn),
		.sampleTick(sampleTick),
		.sample    (sample)
	);

	sampleHistory history (
		.clk      (clk),
		.rstN     (rstN),
		.sample   (sample),
		.prevPos  (prevPos),
		.windowPos(windowPos),
		.full     (full)
	);

	positionTracker tracker (
		.clk       (clk),
		.rstN      (rstN),
		.sample    (sample),
		.prevPos   (prevPos),
		.windowPos (windowPos),
		.full      (full),
		.position  (position),
		.turns     (turns),
		.velocity  (velocity),
		.velValid  (velValid),
		.trackValid(trackValid),
		.jumpErr   (jumpErr)
	);

endmodule

//--- logic/positionTracker.sv
`timescale 1ns/1ps

module positionTracker (
	input  logic                   clk,
	input  logic                   rstN,
	input  encoderPkg::posSample_t sample,
	input  encoderPkg::pos_t       prevPos,
	input  encoderPkg::pos_t       windowPos,
	input  logic                   full,
	output encoderPkg::pos_t       position,
	output encoderPkg::turn_t      turns,
	output encoderPkg::delta_t     velocity,
	output logic                   velValid,
	output logic                   trackValid,
	output logic                   jumpErr     // sticky
);

	import encoderPkg::*;

	logic   seen;      // first sample taken
	delta_t delta;     // step since previous sample
	pos_t   absDelta;
	logic   wrapFwd;   // crossed max to 0
	logic   wrapBack;  // crossed 0 to max
	logic   isJump;

	assign delta    = delta_t'(sample.pos - prevPos);  // mod one turn
	assign absDelta = delta[posWidth-1] ? pos_t'(-delta) : pos_t'(delta);
	assign wrapFwd  = (sample.pos < prevPos) && (delta > 0);
	assign wrapBack = (sample.pos > prevPos) && (delta < 0);
	assign isJump   = absDelta > pos_t'(maxStep);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			seen       <= 1'b0;
			position   <= '0;
			turns      <= '0;
			velValid   <= 1'b0;
			trackValid <= 1'b0;
			jumpErr    <= 1'b0;
		end else begin
			trackValid <= sample.valid;  // pulses in t+2
			if (sample.valid) begin
				seen     <= 1'b1;
				position <= sample.pos;
				velValid <= full;  // window needs histDepth older samples
				// no previous angle on the first sample
				if (seen) begin
					if (wrapFwd) begin
						turns <= turns + turn_t'(1);
					end else if (wrapBack) begin
						turns <= turns - turn_t'(1);
					end
					if (isJump) begin
						jumpErr <= 1'b1;
					end
				end
			end
		end
	end

	// windowed velocity, counts per histDepth ticks
	always_ff @(posedge clk) begin
		if (sample.valid) begin
			velocity <= delta_t'(sample.pos - windowPos);
		end
	end

endmodule

//--- logic/sampleHistory.sv
`timescale 1ns/1ps

module sampleHistory (
	input  logic                   clk,
	input  logic                   rstN,
	input  encoderPkg::posSample_t sample,
	output encoderPkg::pos_t       prevPos,    // last accepted angle
	output encoderPkg::pos_t       windowPos,  // angle histDepth ticks back
	output logic                   full
);

	import encoderPkg::*;

	pos_t     hist [histDepth];  // hist[0] newest
	histCnt_t fill;              // stored samples, saturates

	// shift on the edge that closes the valid cycle
	always_ff @(posedge clk) begin
		if (sample.valid) begin
			hist[0] <= sample.pos;
			for (int i = 1; i < histDepth; i++) begin
				hist[i] <= hist[i-1];
			end
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			fill <= '0;  // empty
		end else if (sample.valid && !full) begin
			fill <= fill + histCnt_t'(1);
		end
	end

	assign full = (fill == histCnt_t'(histDepth));

	// older contents until the shift edge
	assign prevPos   = hist[0];
	assign windowPos = hist[histDepth-1];

endmodule

//--- logic/encoderSampler.sv
`timescale 1ns/1ps

module encoderSampler (
	input  logic                   clk,
	input  logic                   rstN,
	input  encoderPkg::gray_t      grayIn,      // async sensor word
	input  logic                   sampleTick,  // one-cycle strobe
	output encoderPkg::posSample_t sample
);

	import encoderPkg::*;

	gray_t grayMeta;  // first stage, may go metastable
	gray_t graySync;  // safe, one bit changes per step
	pos_t  binNow;    // decoded, combinational
	pos_t  posQ;      // held angle
	logic  validQ;

	// two-flop synchronizer
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			grayMeta <= '0;
			graySync <= '0;
		end else begin
			grayMeta <= grayIn;
			graySync <= grayMeta;
		end
	end

	Gray2Bin #(
		.width(posWidth),
		.speed(gray2BinSpeed)
	) gray2Bin (
		.G(graySync),
		.B(binNow)
	);

	// tick in cycle t, valid in t+1
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
		end else begin
			validQ <= sampleTick;
		end
	end

	always_ff @(posedge clk) begin
		if (sampleTick) begin
			posQ <= binNow;  // capture decoded angle
		end
	end

	assign sample = '{pos: posQ, valid: validQ};

endmodule

//--- prefix/Gray2Bin.sv
`timescale 1ns/1ps

// binary bit i is the xor of gray bits from the msb down to i,
// so the prefix runs from the top and the word is flipped around it
module Gray2Bin #(
	parameter int width = 8,  // word width
	parameter int speed = 0   // prefix variant, see PrefixXor
) (
	input  logic [width-1:0] G,  // gray in
	output logic [width-1:0] B   // binary out
);

	logic [width-1:0] gRev;  // msb moved to bit 0
	logic [width-1:0] bRev;  // prefix result, still flipped

	for (genvar i = 0; i < width; i++) begin : flipIn
		assign gRev[i] = G[width-1-i];
	end

	PrefixXor #(
		.width(width),
		.speed(speed)
	) prefix (
		.PI(gRev),
		.PO(bRev)
	);

	for (genvar i = 0; i < width; i++) begin : flipOut
		assign B[i] = bRev[width-1-i];  // back to lsb first
	end

endmodule

//--- prefix/PrefixXor.sv
`timescale 1ns/1ps

module PrefixXor #(
	parameter int width = 8,  // word width
	parameter int speed = 0   // 0 serial, 1 brent-kung, 2 sklansky
) (
	input  logic [width-1:0] PI,  // lsb first
	output logic [width-1:0] PO   // PO[i] = xor of PI[i:0]
);

	localparam int m = $clog2(width);  // tree depth

	if (speed == 2) begin : sklansky
		// one row per level, row m holds the result
		logic [width-1:0] lvl [0:m];

		assign lvl[0] = PI;

		for (genvar l = 0; l < m; l++) begin : levels
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i >> l) & 1) begin : black
					// upper half of a block takes the lower half's last bit
					assign lvl[l+1][i] = lvl[l][i] ^ lvl[l][((i >> l) << l) - 1];
				end else begin : white
					assign lvl[l+1][i] = lvl[l][i];  // pass
				end
			end
		end

		assign PO = lvl[m];

	end else if (speed == 1) begin : brentKung
		localparam int last = (m == 0) ? 0 : 2 * m - 1;  // final row

		logic [width-1:0] lvl [0:last];

		assign lvl[0] = PI;

		// up-sweep, block sums land on positions 2**l - 1
		for (genvar l = 1; l <= m; l++) begin : up
			for (genvar i = 0; i < width; i++) begin : bits
				if ((i + 1) % (2 ** l) == 0) begin : black
					assign lvl[l][i] = lvl[l-1][i] ^ lvl[l-1][i - 2 ** (l - 1)];
				end else begin : white
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end

		// down-sweep, halving span each row
		for (genvar l = m + 1; l <= last; l++) begin : down
			localparam int s = 2 ** (last - l);  // span of this row
			for (genvar i = 0; i < width; i++) begin : bits
				if (((i + 1) % (2 * s) == s) && (i >= 2 * s)) begin : black
					// lower neighbour already holds its full prefix
					assign lvl[l][i] = lvl[l-1][i] ^ lvl[l-1][i - s];
				end else begin : white
					assign lvl[l][i] = lvl[l-1][i];
				end
			end
		end

		assign PO = lvl[last];

	end else begin : serial
		logic [width-1:0] chain;  // ripple, width-1 gates deep

		assign chain[0] = PI[0];

		for (genvar i = 1; i < width; i++) begin : bits
			assign chain[i] = chain[i-1] ^ PI[i];
		end

		assign PO = chain;
	end

endmodule

//--- common/encoderPkg.sv
package encoderPkg;

	// angle resolution, one turn = 2**posWidth counts
	localparam int posWidth = 12;

	// samples kept for the velocity window
	localparam int histDepth = 4;

	// largest legal step between two samples, below a quarter turn
	localparam int maxStep = 256;

	// prefix network for gray decode
	localparam int gray2BinSpeed = 1;  // 0 serial, 1 brent-kung, 2 sklansky

	// fill counter must reach histDepth
	localparam int histCntWidth = $clog2(histDepth + 1);

	localparam int turnWidth = 8;  // multi-turn range

	typedef logic [posWidth-1:0] pos_t;  // binary shaft angle
	typedef logic [posWidth-1:0] gray_t;  // raw sensor word
	typedef logic signed [posWidth-1:0] delta_t;  // angle change mod one turn
	typedef logic signed [turnWidth-1:0] turn_t;  // signed revolution count
	typedef logic [histCntWidth-1:0] histCnt_t;

	// one accepted sample, valid is a single-cycle strobe
	typedef struct packed {
		pos_t pos;
		logic valid;
	} posSample_t;

endpackage
